// ==== src/xbar_pkg.sv ====
package xbar_pkg;

  // Message payload width
  localparam int MSG_WIDTH = 32;

  // Lane counts on each side of the crossbar
  localparam int N_INPUTS = 4;
  localparam int N_OUTPUTS = 4;

  // Select widths derived from the lane counts
  localparam int IN_SEL_WIDTH = $clog2(N_INPUTS);
  localparam int OUT_SEL_WIDTH = $clog2(N_OUTPUTS);

  // Total width of one route word
  localparam int ROUTE_WIDTH = IN_SEL_WIDTH + OUT_SEL_WIDTH;

  // Depth of each per-lane input queue
  localparam int QUEUE_DEPTH = 2;

  // Input select sits above the output select
  typedef struct packed {
    logic [IN_SEL_WIDTH-1:0]  in_sel;
    logic [OUT_SEL_WIDTH-1:0] out_sel;
  } route_t;

endpackage

// ==== src/input_queue.sv ====
module input_queue (
  input  logic                          clk,
  input  logic                          reset,

  input  logic [xbar_pkg::MSG_WIDTH-1:0] recv_msg,
  input  logic                          recv_val,
  output logic                          recv_rdy,

  output logic [xbar_pkg::MSG_WIDTH-1:0] send_msg,
  output logic                          send_val,
  input  logic                          send_rdy
);

  localparam int PTR_WIDTH = $clog2(xbar_pkg::QUEUE_DEPTH);
  localparam int CNT_WIDTH = $clog2(xbar_pkg::QUEUE_DEPTH + 1);

  logic [xbar_pkg::MSG_WIDTH-1:0] entries [xbar_pkg::QUEUE_DEPTH];

  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [CNT_WIDTH-1:0] count;

  logic push;
  logic pop;

  // Ready drops only when every entry holds a message
  assign recv_rdy = (count != CNT_WIDTH'(xbar_pkg::QUEUE_DEPTH));
  assign send_val = (count != '0);
  assign send_msg = entries[rd_ptr];

  assign push = recv_val && recv_rdy;
  assign pop  = send_val && send_rdy;

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= recv_msg;
    end
  end

  // Pointers wrap naturally at a power-of-two depth
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (push) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (pop) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Simultaneous push and pop leaves the count alone
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (push && !pop) begin
      count <= count + 1'b1;
    end else if (pop && !push) begin
      count <= count - 1'b1;
    end
  end

  count_in_range: assert property (
    @(posedge clk) disable iff (reset)
    count <= CNT_WIDTH'(xbar_pkg::QUEUE_DEPTH)
  );

endmodule

// ==== src/route_crossbar.sv ====
module route_crossbar (
  input  logic                           clk,
  input  logic                           reset,

  input  logic [xbar_pkg::MSG_WIDTH-1:0] recv_msg [xbar_pkg::N_INPUTS],
  input  logic                           recv_val [xbar_pkg::N_INPUTS],
  output logic                           recv_rdy [xbar_pkg::N_INPUTS],

  output logic [xbar_pkg::MSG_WIDTH-1:0] send_msg [xbar_pkg::N_OUTPUTS],
  output logic                           send_val [xbar_pkg::N_OUTPUTS],
  input  logic                           send_rdy [xbar_pkg::N_OUTPUTS],

  input  xbar_pkg::route_t               route,
  input  logic                           route_val
);

  xbar_pkg::route_t route_q;

  logic [xbar_pkg::IN_SEL_WIDTH-1:0]  in_sel;
  logic [xbar_pkg::OUT_SEL_WIDTH-1:0] out_sel;

  logic [xbar_pkg::N_OUTPUTS-1:0] send_val_vec;

  // Route takes effect the cycle after its strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      route_q <= '0;
    end else if (route_val) begin
      route_q <= route;
    end
  end

  assign in_sel  = route_q.in_sel;
  assign out_sel = route_q.out_sel;

  // Only the routed output sees the selected head
  always_comb begin
    for (int i = 0; i < xbar_pkg::N_OUTPUTS; i++) begin
      if (out_sel == xbar_pkg::OUT_SEL_WIDTH'(i)) begin
        send_msg[i] = recv_msg[in_sel];
        send_val[i] = recv_val[in_sel];
      end else begin
        send_msg[i] = '0;
        send_val[i] = 1'b0;
      end
    end
  end

  // Unselected inputs stall
  always_comb begin
    for (int i = 0; i < xbar_pkg::N_INPUTS; i++) begin
      if (in_sel == xbar_pkg::IN_SEL_WIDTH'(i)) begin
        recv_rdy[i] = send_rdy[out_sel];
      end else begin
        recv_rdy[i] = 1'b0;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < xbar_pkg::N_OUTPUTS; i++) begin
      send_val_vec[i] = send_val[i];
    end
  end

  // A routed transfer never lands on more than one output
  single_output: assert property (
    @(posedge clk) disable iff (reset)
    $onehot0(send_val_vec)
  );

endmodule

// ==== src/output_register.sv ====
module output_register (
  input  logic                           clk,
  input  logic                           reset,

  input  logic [xbar_pkg::MSG_WIDTH-1:0] recv_msg,
  input  logic                           recv_val,
  output logic                           recv_rdy,

  output logic [xbar_pkg::MSG_WIDTH-1:0] send_msg,
  output logic                           send_val,
  input  logic                           send_rdy
);

  logic                           full;
  logic [xbar_pkg::MSG_WIDTH-1:0] data;

  logic load;
  logic unload;

  // Ready when empty or draining this cycle
  assign recv_rdy = !full || send_rdy;

  assign load   = recv_val && recv_rdy;
  assign unload = full && send_rdy;

  assign send_val = full;
  assign send_msg = data;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (load) begin
      full <= 1'b1;
    end else if (unload) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      data <= recv_msg;
    end
  end

  // Stalled output holds its message
  hold_while_stalled: assert property (
    @(posedge clk) disable iff (reset)
    (send_val && !send_rdy) |=> (send_val && $stable(send_msg))
  );

endmodule

// ==== src/switch_top.sv ====
module switch_top (
  input  logic                           clk,
  input  logic                           reset,

  input  logic [xbar_pkg::MSG_WIDTH-1:0] in_msg [xbar_pkg::N_INPUTS],
  input  logic                           in_val [xbar_pkg::N_INPUTS],
  output logic                           in_rdy [xbar_pkg::N_INPUTS],

  output logic [xbar_pkg::MSG_WIDTH-1:0] out_msg [xbar_pkg::N_OUTPUTS],
  output logic                           out_val [xbar_pkg::N_OUTPUTS],
  input  logic                           out_rdy [xbar_pkg::N_OUTPUTS],

  input  xbar_pkg::route_t               route,
  input  logic                           route_val
);

  // Queue heads toward the crossbar
  logic [xbar_pkg::MSG_WIDTH-1:0] q_msg [xbar_pkg::N_INPUTS];
  logic                           q_val [xbar_pkg::N_INPUTS];
  logic                           q_rdy [xbar_pkg::N_INPUTS];

  // Crossbar outputs toward the output registers
  logic [xbar_pkg::MSG_WIDTH-1:0] x_msg [xbar_pkg::N_OUTPUTS];
  logic                           x_val [xbar_pkg::N_OUTPUTS];
  logic                           x_rdy [xbar_pkg::N_OUTPUTS];

  for (genvar i = 0; i < xbar_pkg::N_INPUTS; i++) begin : g_in
    input_queue queue_i (
      .clk      (clk),
      .reset    (reset),
      .recv_msg (in_msg[i]),
      .recv_val (in_val[i]),
      .recv_rdy (in_rdy[i]),
      .send_msg (q_msg[i]),
      .send_val (q_val[i]),
      .send_rdy (q_rdy[i])
    );
  end

  route_crossbar xbar_i (
    .clk       (clk),
    .reset     (reset),
    .recv_msg  (q_msg),
    .recv_val  (q_val),
    .recv_rdy  (q_rdy),
    .send_msg  (x_msg),
    .send_val  (x_val),
    .send_rdy  (x_rdy),
    .route     (route),
    .route_val (route_val)
  );

  for (genvar i = 0; i < xbar_pkg::N_OUTPUTS; i++) begin : g_out
    output_register oreg_i (
      .clk      (clk),
      .reset    (reset),
      .recv_msg (x_msg[i]),
      .recv_val (x_val[i]),
      .recv_rdy (x_rdy[i]),
      .send_msg (out_msg[i]),
      .send_val (out_val[i]),
      .send_rdy (out_rdy[i])
    );
  end

endmodule

// ==== tests/switch_tb.sv ====
module switch_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MODEL_DEPTH = 64;
  localparam int N_PAIRS = xbar_pkg::N_INPUTS * xbar_pkg::N_OUTPUTS;
  localparam int N_ROUTES = 20;
  localparam int RUN_CYCLES = 60;
  localparam int DRAIN_TIMEOUT = 500;
  localparam int LATENCY_TIMEOUT = 20;

  logic clk;
  logic reset;

  logic [xbar_pkg::MSG_WIDTH-1:0] in_msg [xbar_pkg::N_INPUTS];
  logic                           in_val [xbar_pkg::N_INPUTS];
  logic                           in_rdy [xbar_pkg::N_INPUTS];

  logic [xbar_pkg::MSG_WIDTH-1:0] out_msg [xbar_pkg::N_OUTPUTS];
  logic                           out_val [xbar_pkg::N_OUTPUTS];
  logic                           out_rdy [xbar_pkg::N_OUTPUTS];

  xbar_pkg::route_t route;
  logic             route_val;

  // One circular buffer per input lane as the reference model
  logic [xbar_pkg::MSG_WIDTH-1:0] model_mem [xbar_pkg::N_INPUTS][MODEL_DEPTH];
  int model_head [xbar_pkg::N_INPUTS];
  int model_tail [xbar_pkg::N_INPUTS];

  logic accepted [xbar_pkg::N_INPUTS];
  int   pair_hits [xbar_pkg::N_INPUTS][xbar_pkg::N_OUTPUTS];

  int   cur_in;
  int   cur_out;
  logic rdy_random;
  int   seed;
  int   seq;
  int   error_count;
  int   checked_count;

  switch_top dut_i (
    .clk       (clk),
    .reset     (reset),
    .in_msg    (in_msg),
    .in_val    (in_val),
    .in_rdy    (in_rdy),
    .out_msg   (out_msg),
    .out_val   (out_val),
    .out_rdy   (out_rdy),
    .route     (route),
    .route_val (route_val)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic int model_count(input int lane);
    return model_tail[lane] - model_head[lane];
  endfunction

  function automatic logic any_out_val();
    logic busy;
    busy = 1'b0;
    for (int o = 0; o < xbar_pkg::N_OUTPUTS; o++) begin
      busy = busy | out_val[o];
    end
    return busy;
  endfunction

  // Lane tag on top, sequence number in the middle, random low half
  task automatic new_msg(input int lane, output logic [xbar_pkg::MSG_WIDTH-1:0] msg);
    logic [31:0] rnd;
    rnd = $random(seed);
    seq = seq + 1;
    msg = {2'(lane), 14'(seq), rnd[15:0]};
  endtask

  // Sample a half cycle before the edge that the values apply to
  always @(negedge clk) begin : monitor
    logic                           exp_rdy;
    logic [xbar_pkg::MSG_WIDTH-1:0] expected;
    if (reset) begin
      for (int i = 0; i < xbar_pkg::N_INPUTS; i++) begin
        accepted[i] = 1'b0;
      end
    end else begin
      for (int i = 0; i < xbar_pkg::N_INPUTS; i++) begin
        // A blocked lane holds exactly what it accepted
        if (i != cur_in) begin
          exp_rdy = (model_count(i) < 2);
          if (in_rdy[i] !== exp_rdy) begin
            $display("Error in_rdy[%0d]: expected %h, got %h", i, exp_rdy, in_rdy[i]);
            error_count++;
          end
        end
        accepted[i] = in_val[i] && in_rdy[i];
        if (accepted[i]) begin
          model_mem[i][model_tail[i] % MODEL_DEPTH] = in_msg[i];
          model_tail[i]++;
        end
      end
      for (int o = 0; o < xbar_pkg::N_OUTPUTS; o++) begin
        if (out_val[o] && o != cur_out) begin
          $display("Error out_val[%0d]: expected %h, got %h", o, 1'b0, out_val[o]);
          error_count++;
        end else if (out_val[o] && out_rdy[o]) begin
          if (model_count(cur_in) == 0) begin
            $display("Output %0d delivered a message that input %0d never accepted",
                     o, cur_in);
            error_count++;
          end else begin
            expected = model_mem[cur_in][model_head[cur_in] % MODEL_DEPTH];
            if (out_msg[o] !== expected) begin
              $display("Error out_msg[%0d]: expected %h, got %h", o, expected, out_msg[o]);
              error_count++;
            end
            model_head[cur_in]++;
            pair_hits[cur_in][cur_out]++;
            checked_count++;
          end
        end
      end
    end
  end

  task automatic finish_run();
    $display("Messages checked: %0d, errors: %0d", checked_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  // One clock cycle of stimulus; a lane offering a message holds it until taken
  task automatic step(input logic gen);
    logic [31:0] rnd;
    @(posedge clk);
    #1;
    for (int o = 0; o < xbar_pkg::N_OUTPUTS; o++) begin
      out_rdy[o] = 1'b1;
    end
    if (rdy_random) begin
      rnd = $random(seed);
      out_rdy[cur_out] = rnd[0];
    end
    for (int i = 0; i < xbar_pkg::N_INPUTS; i++) begin
      if (!in_val[i] || accepted[i]) begin
        rnd = $random(seed);
        if (gen && rnd[1:0] != 2'b00) begin
          in_val[i] = 1'b1;
          new_msg(i, in_msg[i]);
        end else begin
          in_val[i] = 1'b0;
        end
      end
    end
  endtask

  task automatic set_route(input int in_lane, input int out_lane);
    step(1'b0);
    route.in_sel = xbar_pkg::IN_SEL_WIDTH'(in_lane);
    route.out_sel = xbar_pkg::OUT_SEL_WIDTH'(out_lane);
    route_val = 1'b1;
    step(1'b0);
    route_val = 1'b0;
    cur_in = in_lane;
    cur_out = out_lane;
  endtask

  task automatic drain();
    int   cycles;
    logic busy;
    cycles = 0;
    busy = 1'b1;
    while (busy) begin
      step(1'b0);
      busy = (model_count(cur_in) != 0) || in_val[cur_in] || any_out_val();
      cycles++;
      if (busy && cycles > DRAIN_TIMEOUT) begin
        $display("Timeout: input %0d did not drain through output %0d", cur_in, cur_out);
        error_count++;
        finish_run();
      end
    end
  endtask

  task automatic check_reset_state();
    for (int i = 0; i < xbar_pkg::N_INPUTS; i++) begin
      if (in_rdy[i] !== 1'b1) begin
        $display("Error in_rdy[%0d]: expected %h, got %h", i, 1'b1, in_rdy[i]);
        error_count++;
      end
    end
    for (int o = 0; o < xbar_pkg::N_OUTPUTS; o++) begin
      if (out_val[o] !== 1'b0) begin
        $display("Error out_val[%0d]: expected %h, got %h", o, 1'b0, out_val[o]);
        error_count++;
      end
    end
  endtask

  // Offer one message on an idle path and count cycles until out_val
  task automatic check_latency();
    int   cycles;
    logic seen;
    rdy_random = 1'b0;
    drain();
    in_val[cur_in] = 1'b1;
    new_msg(cur_in, in_msg[cur_in]);
    if (in_rdy[cur_in] !== 1'b1) begin
      $display("Error in_rdy[%0d]: expected %h, got %h", cur_in, 1'b1, in_rdy[cur_in]);
      error_count++;
    end
    cycles = 0;
    seen = 1'b0;
    while (!seen) begin
      step(1'b0);
      cycles++;
      seen = out_val[cur_out];
      if (!seen && cycles > LATENCY_TIMEOUT) begin
        $display("Timeout: single message never reached output %0d", cur_out);
        error_count++;
        finish_run();
      end
    end
    if (cycles != 2) begin
      $display("Error out_val[%0d] latency: expected %h, got %h", cur_out, 2, cycles);
      error_count++;
    end
    rdy_random = 1'b1;
  endtask

  initial begin : main
    int          pair_order [N_PAIRS];
    int          j;
    int          tmp;
    int          pair;
    logic [31:0] rnd;

    seed = 27;
    seq = 0;
    error_count = 0;
    checked_count = 0;
    cur_in = 0;
    cur_out = 0;
    rdy_random = 1'b1;
    reset = 1'b1;
    route = '0;
    route_val = 1'b0;
    for (int i = 0; i < xbar_pkg::N_INPUTS; i++) begin
      in_msg[i] = '0;
      in_val[i] = 1'b0;
      accepted[i] = 1'b0;
      model_head[i] = 0;
      model_tail[i] = 0;
      for (int o = 0; o < xbar_pkg::N_OUTPUTS; o++) begin
        pair_hits[i][o] = 0;
      end
    end
    for (int o = 0; o < xbar_pkg::N_OUTPUTS; o++) begin
      out_rdy[o] = 1'b1;
    end

    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    check_reset_state();

    // Stored route after reset is input 0 to output 0
    check_latency();

    // Shuffled order so that every lane pair gets a route
    for (int i = 0; i < N_PAIRS; i++) begin
      pair_order[i] = i;
    end
    for (int i = N_PAIRS - 1; i > 0; i--) begin
      rnd = $random(seed);
      j = int'(rnd % 32'(i + 1));
      tmp = pair_order[i];
      pair_order[i] = pair_order[j];
      pair_order[j] = tmp;
    end

    for (int r = 0; r < N_ROUTES; r++) begin
      if (r < N_PAIRS) begin
        pair = pair_order[r];
      end else begin
        rnd = $random(seed);
        pair = int'(rnd[3:0]);
      end
      drain();
      set_route(pair / xbar_pkg::N_OUTPUTS, pair % xbar_pkg::N_OUTPUTS);
      repeat (RUN_CYCLES) step(1'b1);
    end

    check_latency();

    // Route each lane once more to release what it still holds
    for (int i = 0; i < xbar_pkg::N_INPUTS; i++) begin
      rnd = $random(seed);
      drain();
      set_route(i, int'(rnd[1:0]));
      drain();
    end

    for (int i = 0; i < xbar_pkg::N_INPUTS; i++) begin
      if (model_count(i) != 0) begin
        $display("Input %0d still has %0d undelivered messages", i, model_count(i));
        error_count++;
      end
      for (int o = 0; o < xbar_pkg::N_OUTPUTS; o++) begin
        if (pair_hits[i][o] == 0) begin
          $display("No message crossed from input %0d to output %0d", i, o);
          error_count++;
        end
      end
    end

    finish_run();
  end

endmodule

// ==== sim.f ====
src/xbar_pkg.sv
src/input_queue.sv
src/route_crossbar.sv
src/output_register.sv
src/switch_top.sv
tests/switch_tb.sv

// ==== Makefile ====
TOP := switch_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f sim.f -o sim_bin

run: build
	./obj_dir/sim_bin | tee $(LOG)
	@grep -q "^Testbench passed$$" $(LOG) || (echo "Simulation did not pass"; exit 1)

lint:
	verilator --lint-only -Wall --top-module switch_top \
		src/xbar_pkg.sv \
		src/input_queue.sv \
		src/route_crossbar.sv \
		src/output_register.sv \
		src/switch_top.sv

clean:
	rm -rf obj_dir $(LOG)
